//--- rtl/cntr_bs_macros.svh
`default_nettype none

`ifndef CNTR_BS_MACROS_SVH
`define CNTR_BS_MACROS_SVH

// ********************
// Bank scheduler sizing
// ********************

`define CNTR_BS_RA        8   // Row address width
`define CNTR_BS_RD_NUM    4   // Read scheduler fifos
`define CNTR_BS_WR_NUM    3   // Write scheduler fifos
`define CNTR_BS_FIFO_NUM  7   // Read plus write fifos

// Per fifo storage
`define CNTR_BS_DEPTH     4   // Entries per fifo
`define CNTR_BS_MID       2   // Occupancy that raises the mid flag

`endif

`default_nettype wire

//--- rtl/cntr_bs_pkg.sv
`default_nettype none

package cntr_bs_pkg;

  // ********************
  // Transaction types
  // ********************

  // Read or write, one bit as carried on t_i and cmd_type_o
  typedef enum logic {
    TXN_READ  = 1'b0,  // Goes to fifos 0..3
    TXN_WRITE = 1'b1   // Goes to fifos 4..6
  } txn_type_e;

  // ********************
  // Handshake FSMs
  // ********************

  // Upstream side, transaction controller to scheduler
  typedef enum logic [1:0] {
    IN_IDLE     = 2'd0,  // Waiting for req with a free fifo
    IN_ACK      = 2'd1,  // Entry pushed, ack just raised
    IN_WAIT_LOW = 2'd2   // Holding ack until req drops
  } in_state_e;

  // Downstream side, scheduler to command stage
  typedef enum logic [1:0] {
    OUT_IDLE     = 2'd0,  // Free to pop the granted fifo
    OUT_REQ      = 2'd1,  // cmd_req high, waiting for ack
    OUT_WAIT_LOW = 2'd2   // cmd_req dropped, waiting for ack low
  } out_state_e;

endpackage

`default_nettype wire

//--- rtl/cntr_bs_sel.sv
`include "cntr_bs_macros.svh"
`timescale 1ns/100ps
`default_nettype none

module cntr_bs_sel import cntr_bs_pkg::*; (
  input  wire logic                                         valid_i,   // Request pending
  input  wire logic      [`CNTR_BS_RA-1:0]                  ra_i,      // Incoming row
  input  wire txn_type_e                                    t_i,       // Incoming type
  input  wire logic      [`CNTR_BS_FIFO_NUM-1:0][`CNTR_BS_RA-1:0] last_ra_i,
  input  wire logic      [`CNTR_BS_FIFO_NUM-1:0]            full_i,
  input  wire logic      [`CNTR_BS_FIFO_NUM-1:0]            mid_i,
  input  wire logic      [`CNTR_BS_FIFO_NUM-1:0]            empty_i,
  output logic           [`CNTR_BS_FIFO_NUM-1:0]            push_o     // One-hot or zero
);

  localparam int FIFO_NUM = `CNTR_BS_FIFO_NUM;

  // Group masks, reads in the low bits, writes above them
  localparam logic [FIFO_NUM-1:0] RD_MASK = FIFO_NUM'((1 << `CNTR_BS_RD_NUM) - 1);
  localparam logic [FIFO_NUM-1:0] WR_MASK =
    FIFO_NUM'(((1 << `CNTR_BS_WR_NUM) - 1) << `CNTR_BS_RD_NUM);

  // ********************
  // Priority search
  // ********************

  // Lowest set bit kept, seven fifos wide
  function automatic logic [FIFO_NUM-1:0] first_one(input logic [FIFO_NUM-1:0] vec);
    casez (vec)
      7'b??????1: first_one = 7'b0000001;
      7'b?????10: first_one = 7'b0000010;
      7'b????100: first_one = 7'b0000100;
      7'b???1000: first_one = 7'b0001000;
      7'b??10000: first_one = 7'b0010000;
      7'b?100000: first_one = 7'b0100000;
      7'b1000000: first_one = 7'b1000000;
      default:    first_one = '0;         // Nothing qualifies
    endcase
  endfunction

  logic [FIFO_NUM-1:0] grp;         // Fifos of this type
  logic [FIFO_NUM-1:0] hits;        // Row match, any type
  logic [FIFO_NUM-1:0] hit_vec;     // Step 1 candidates
  logic [FIFO_NUM-1:0] empty_vec;   // Step 2 candidates
  logic [FIFO_NUM-1:0] low_vec;     // Step 3 candidates
  logic [FIFO_NUM-1:0] unfull_vec;  // Step 4 candidates
  logic [FIFO_NUM-1:0] pick;

  assign grp = (t_i == TXN_READ) ? RD_MASK : WR_MASK;

  // Row hit only counts on a fifo that can still take an entry
  always_comb begin
    for (int i = 0; i < FIFO_NUM; i++) begin
      hits[i] = !full_i[i] && (last_ra_i[i] == ra_i);
    end
  end

  assign hit_vec    = hits     & grp;
  assign empty_vec  = empty_i  & grp;
  assign low_vec    = ~mid_i   & grp;  // Below mid implies not full
  assign unfull_vec = ~full_i  & grp;

  // ********************
  // Greedy pick
  // ********************

  always_comb begin
    if (|hit_vec) begin
      pick = first_one(hit_vec);        // Keep the open row streaming
    end else if (|empty_vec) begin
      pick = first_one(empty_vec);
    end else if (|low_vec) begin
      pick = first_one(low_vec);
    end else begin
      pick = first_one(unfull_vec);     // Zero when the group is full
    end
  end

  assign push_o = valid_i ? pick : '0;  // Nothing without a request

endmodule

`default_nettype wire

//--- rtl/cntr_bs_fifo.sv
`include "cntr_bs_macros.svh"
`timescale 1ns/100ps
`default_nettype none

module cntr_bs_fifo (
  input  wire logic                   clk_i,
  input  wire logic                   arst_n_i,
  input  wire logic                   push_i,     // Store ra_i
  input  wire logic                   pop_i,      // Drop head entry
  input  wire logic [`CNTR_BS_RA-1:0] ra_i,
  output logic      [`CNTR_BS_RA-1:0] head_ra_o,  // Oldest entry
  output logic      [`CNTR_BS_RA-1:0] last_ra_o,  // Most recent push
  output logic                        full_o,
  output logic                        mid_o,
  output logic                        empty_o
);

  localparam int DEPTH = `CNTR_BS_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [`CNTR_BS_RA-1:0] mem [DEPTH];  // Row storage
  logic [PTR_W-1:0]       wr_ptr;
  logic [PTR_W-1:0]       rd_ptr;
  logic [CNT_W-1:0]       count;        // Occupancy
  logic                   do_push;
  logic                   do_pop;

  // Full before the edge means no push, even with a pop on the same edge
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // ********************
  // Storage
  // ********************

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr] <= ra_i;
    end
  end

  assign head_ra_o = mem[rd_ptr];

  // ********************
  // Pointers and count
  // ********************

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      last_ra_o <= '0;                  // Row 0 counts as last row after reset
    end else begin
      if (do_push) begin
        wr_ptr    <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
        last_ra_o <= ra_i;              // Survives the fifo draining
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;        // Both or neither
      endcase
    end
  end

  // Flags straight from the count
  assign full_o  = (count == CNT_W'(DEPTH));
  assign mid_o   = (count >= CNT_W'(`CNTR_BS_MID));
  assign empty_o = (count == '0);

endmodule

`default_nettype wire

//--- rtl/cntr_bs_arb.sv
`include "cntr_bs_macros.svh"
`timescale 1ns/100ps
`default_nettype none

module cntr_bs_arb (
  input  wire logic                                 clk_i,
  input  wire logic                                 arst_n_i,
  input  wire logic [`CNTR_BS_FIFO_NUM-1:0]         empty_i,        // One per fifo
  input  wire logic                                 advance_i,      // Grant was used
  output logic      [$clog2(`CNTR_BS_FIFO_NUM)-1:0] grant_o,        // Granted fifo
  output logic                                      grant_valid_o   // Some fifo holds data
);

  localparam int FIFO_NUM = `CNTR_BS_FIFO_NUM;
  localparam int IDX_W    = $clog2(FIFO_NUM);

  logic [IDX_W-1:0] ptr_q;      // Search starts here
  logic [IDX_W-1:0] grant_idx;
  logic             found;

  // ********************
  // Rotating search
  // ********************

  // First non-empty fifo at or after the pointer, 6 wraps to 0
  always_comb begin
    int idx;
    idx       = 0;
    found     = 1'b0;
    grant_idx = ptr_q;
    for (int k = 0; k < FIFO_NUM; k++) begin
      idx = (int'(ptr_q) + k) % FIFO_NUM;
      if (!found && !empty_i[idx]) begin
        found     = 1'b1;
        grant_idx = IDX_W'(idx);
      end
    end
  end

  assign grant_o       = grant_idx;
  assign grant_valid_o = found;

  // ********************
  // Pointer update
  // ********************

  // Next search starts one past the fifo just served
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ptr_q <= '0;                      // Fifo 0 goes first
    end else if (advance_i) begin
      ptr_q <= (grant_idx == IDX_W'(FIFO_NUM - 1)) ? '0 : grant_idx + 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- rtl/cntr_bs_ctrl.sv
`include "cntr_bs_macros.svh"
`timescale 1ns/100ps
`default_nettype none

module cntr_bs_ctrl import cntr_bs_pkg::*; (
  input  wire logic                                 clk_i,
  input  wire logic                                 arst_n_i,
  input  wire logic                                 req_i,          // Upstream request
  input  wire logic [`CNTR_BS_FIFO_NUM-1:0]         sel_push_i,     // Selector choice
  input  wire logic [$clog2(`CNTR_BS_FIFO_NUM)-1:0] grant_i,        // Arbiter choice
  input  wire logic                                 grant_valid_i,
  input  wire logic [`CNTR_BS_RA-1:0]               head_ra_i,      // Head of granted fifo
  input  wire logic                                 cmd_ack_i,      // Command stage ack
  output logic                                      ack_o,
  output logic                                      sel_valid_o,
  output logic      [`CNTR_BS_FIFO_NUM-1:0]         push_o,         // Single-cycle strobes
  output logic      [`CNTR_BS_FIFO_NUM-1:0]         pop_o,
  output logic                                      advance_o,      // Move arbiter pointer
  output logic                                      cmd_req_o,
  output logic      [`CNTR_BS_RA-1:0]               cmd_ra_o,
  output txn_type_e                                 cmd_type_o,
  output logic      [$clog2(`CNTR_BS_FIFO_NUM)-1:0] cmd_fifo_o
);

  localparam int FIFO_NUM = `CNTR_BS_FIFO_NUM;
  localparam int IDX_W    = $clog2(FIFO_NUM);

  in_state_e  in_state_q;
  out_state_e out_state_q;
  logic       accept;   // Push happens on this edge
  logic       issue;    // Pop happens on this edge

  // ********************
  // Upstream handshake
  // ********************

  assign sel_valid_o = (in_state_q == IN_IDLE) && req_i;
  assign accept      = sel_valid_o && |sel_push_i;  // No free fifo, request waits
  assign push_o      = accept ? sel_push_i : '0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      in_state_q <= IN_IDLE;
    end else begin
      case (in_state_q)
        IN_IDLE: begin
          if (accept) in_state_q <= IN_ACK;        // ack rises with the push
        end
        IN_ACK: begin
          in_state_q <= req_i ? IN_WAIT_LOW : IN_IDLE;
        end
        IN_WAIT_LOW: begin
          if (!req_i) in_state_q <= IN_IDLE;       // ack falls here
        end
        default: in_state_q <= IN_IDLE;
      endcase
    end
  end

  assign ack_o = (in_state_q != IN_IDLE);  // Straight from the state flops

  // ********************
  // Downstream handshake
  // ********************

  assign issue     = (out_state_q == OUT_IDLE) && grant_valid_i;
  assign pop_o     = issue ? (FIFO_NUM'(1) << grant_i) : '0;
  assign advance_o = issue;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_state_q <= OUT_IDLE;
    end else begin
      case (out_state_q)
        OUT_IDLE: begin
          if (issue) out_state_q <= OUT_REQ;
        end
        OUT_REQ: begin
          if (cmd_ack_i) out_state_q <= OUT_WAIT_LOW;  // Stage took it
        end
        OUT_WAIT_LOW: begin
          if (!cmd_ack_i) out_state_q <= OUT_IDLE;     // Four-phase closed
        end
        default: out_state_q <= OUT_IDLE;
      endcase
    end
  end

  assign cmd_req_o = (out_state_q == OUT_REQ);

  // Command fields, taken from the head before it is popped
  always_ff @(posedge clk_i) begin
    if (issue) begin
      cmd_ra_o   <= head_ra_i;
      cmd_fifo_o <= grant_i;
      cmd_type_o <= (grant_i < IDX_W'(`CNTR_BS_RD_NUM)) ? TXN_READ : TXN_WRITE;
    end
  end

endmodule

`default_nettype wire

//--- rtl/cntr_bs_top.sv
`include "cntr_bs_macros.svh"
`timescale 1ns/100ps
`default_nettype none

module cntr_bs_top import cntr_bs_pkg::*; (
  input  wire logic                                 clk_i,
  input  wire logic                                 arst_n_i,
  input  wire logic                                 req_i,      // Transaction in
  input  wire logic      [`CNTR_BS_RA-1:0]          ra_i,
  input  wire txn_type_e                            t_i,
  input  wire logic                                 cmd_ack_i,  // Command stage ack
  output logic                                      ack_o,
  output logic                                      cmd_req_o,  // Command out
  output logic           [`CNTR_BS_RA-1:0]          cmd_ra_o,
  output txn_type_e                                 cmd_type_o,
  output logic           [$clog2(`CNTR_BS_FIFO_NUM)-1:0] cmd_fifo_o
);

  localparam int FIFO_NUM = `CNTR_BS_FIFO_NUM;
  localparam int IDX_W    = $clog2(FIFO_NUM);

  logic                                    sel_valid;
  logic [FIFO_NUM-1:0]                     sel_push;   // Selector to controller
  logic [FIFO_NUM-1:0]                     push;       // Controller to fifos
  logic [FIFO_NUM-1:0]                     pop;
  logic [FIFO_NUM-1:0]                     full;
  logic [FIFO_NUM-1:0]                     mid;
  logic [FIFO_NUM-1:0]                     empty;
  logic [FIFO_NUM-1:0][`CNTR_BS_RA-1:0]    last_ra;
  logic [FIFO_NUM-1:0][`CNTR_BS_RA-1:0]    fifo_head;
  logic [`CNTR_BS_RA-1:0]                  head_ra;    // Granted fifo head
  logic [IDX_W-1:0]                        grant;
  logic                                    grant_valid;
  logic                                    advance;

  cntr_bs_ctrl i_cntr_bs_ctrl (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .req_i         (req_i),
    .sel_push_i    (sel_push),
    .grant_i       (grant),
    .grant_valid_i (grant_valid),
    .head_ra_i     (head_ra),
    .cmd_ack_i     (cmd_ack_i),
    .ack_o         (ack_o),
    .sel_valid_o   (sel_valid),
    .push_o        (push),
    .pop_o         (pop),
    .advance_o     (advance),
    .cmd_req_o     (cmd_req_o),
    .cmd_ra_o      (cmd_ra_o),
    .cmd_type_o    (cmd_type_o),
    .cmd_fifo_o    (cmd_fifo_o)
  );

  cntr_bs_sel i_cntr_bs_sel (
    .valid_i   (sel_valid),
    .ra_i      (ra_i),
    .t_i       (t_i),
    .last_ra_i (last_ra),
    .full_i    (full),
    .mid_i     (mid),
    .empty_i   (empty),
    .push_o    (sel_push)
  );

  // ********************
  // Scheduler fifos
  // ********************

  // Reads in 0..3, writes in 4..6
  for (genvar g = 0; g < FIFO_NUM; g++) begin : g_fifo
    cntr_bs_fifo i_cntr_bs_fifo (
      .clk_i     (clk_i),
      .arst_n_i  (arst_n_i),
      .push_i    (push[g]),
      .pop_i     (pop[g]),
      .ra_i      (ra_i),
      .head_ra_o (fifo_head[g]),
      .last_ra_o (last_ra[g]),
      .full_o    (full[g]),
      .mid_o     (mid[g]),
      .empty_o   (empty[g])
    );
  end

  assign head_ra = fifo_head[grant];  // Head mux on the grant

  cntr_bs_arb i_cntr_bs_arb (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .empty_i       (empty),
    .advance_i     (advance),
    .grant_o       (grant),
    .grant_valid_o (grant_valid)
  );

endmodule

`default_nettype wire

//--- bench/cntr_bs_clkgen.sv
`timescale 1ns/100ps
`default_nettype none

module cntr_bs_clkgen (
  output logic clk_o,
  output logic arst_n_o
);

  // 8 ns period
  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // Reset held for 10 cycles, released just after an edge
  initial begin
    arst_n_o = 1'b0;
    repeat (10) @(posedge clk_o);
    #1;
    arst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- bench/cntr_bs_assertions.sv
`include "cntr_bs_macros.svh"
`timescale 1ns/100ps
`default_nettype none

module cntr_bs_assertions (
  input wire logic                         clk_i,
  input wire logic                         arst_n_i,
  input wire logic                         req_i,
  input wire logic                         ack_i,
  input wire logic [`CNTR_BS_FIFO_NUM-1:0] push_i,
  input wire logic [`CNTR_BS_FIFO_NUM-1:0] pop_i,
  input wire logic                         cmd_req_i,
  input wire logic                         cmd_ack_i
);

  localparam int FIFO_NUM = `CNTR_BS_FIFO_NUM;
  localparam int CNT_W    = $clog2(`CNTR_BS_DEPTH + 1);

  logic [CNT_W-1:0]    occ [FIFO_NUM];  // Fill level seen through the strobes
  logic [FIFO_NUM-1:0] occ_empty;

  // Fill level rebuilt from the push and pop strobes
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < FIFO_NUM; i++) begin
        occ[i] <= '0;
      end
    end else begin
      for (int i = 0; i < FIFO_NUM; i++) begin
        occ[i] <= occ[i] + CNT_W'(push_i[i]) - CNT_W'(pop_i[i]);
      end
    end
  end

  always_comb begin
    for (int i = 0; i < FIFO_NUM; i++) begin
      occ_empty[i] = (occ[i] == '0);
    end
  end

  // ********************
  // Upstream four-phase
  // ********************

  a_push_onehot: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(push_i)) else $error("push strobe hits more than one fifo");

  a_ack_rise: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $rose(ack_i) |-> $past(req_i)) else $error("ack rose without a request");

  a_ack_fall: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $fell(ack_i) |-> !$past(req_i)) else $error("ack fell while request still high");

  // ********************
  // Downstream four-phase
  // ********************

  a_cmd_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    cmd_req_i && !cmd_ack_i |=> cmd_req_i) else $error("cmd_req dropped before its ack");

  a_cmd_rise: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $rose(cmd_req_i) |-> !$past(cmd_ack_i)) else $error("cmd_req rose with ack high");

  // Popped fifo must hold an entry
  a_pop_filled: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    |pop_i |-> !(|(pop_i & occ_empty))) else $error("pop from an empty fifo");

endmodule

bind cntr_bs_ctrl cntr_bs_assertions i_cntr_bs_assertions (
  .clk_i         (clk_i),
  .arst_n_i      (arst_n_i),
  .req_i         (req_i),
  .ack_i         (ack_o),
  .push_i        (push_o),
  .pop_i         (pop_o),
  .cmd_req_i     (cmd_req_o),
  .cmd_ack_i     (cmd_ack_i)
);

`default_nettype wire

//--- bench/cntr_bs_tb.sv
`include "cntr_bs_macros.svh"
`timescale 1ns/100ps
`default_nettype none

module cntr_bs_tb import cntr_bs_pkg::*; ();

  localparam int RA          = `CNTR_BS_RA;
  localparam int RD_NUM      = `CNTR_BS_RD_NUM;
  localparam int FIFO_NUM    = `CNTR_BS_FIFO_NUM;
  localparam int IDX_W       = $clog2(FIFO_NUM);
  localparam int NUM_TXN     = 400;
  localparam int TIMEOUT_CYC = NUM_TXN * 40;

  logic             clk;
  logic             arst_n;
  logic             req;
  logic [RA-1:0]    ra;
  txn_type_e        t;
  logic             cmd_ack;
  logic             ack;
  logic             cmd_req;
  logic [RA-1:0]    cmd_ra;
  txn_type_e        cmd_type;
  logic [IDX_W-1:0] cmd_fifo;

  int seed = 45;          // Source stream
  int snk_seed;           // Sink stream, drawn from the source seed
  int cycles = 0;
  int issued = 0;         // Commands checked by the model
  logic src_done = 1'b0;
  int ra_errs = 0;
  int fifo_errs = 0;
  int type_errs = 0;
  int flow_errs = 0;

  // Reference model, one queue per fifo
  logic [RA-1:0] q_ra [FIFO_NUM][$];
  txn_type_e     q_t [FIFO_NUM][$];
  logic [RA-1:0] last_ra [FIFO_NUM];
  int            rr_ptr = 0;
  logic          prev_req = 1'b0;
  logic          prev_ack = 1'b0;
  logic          prev_cmd_req = 1'b0;
  logic          prev_cmd_ack = 1'b0;
  logic [RA-1:0] prev_ra = '0;
  txn_type_e     prev_t = TXN_READ;

  cntr_bs_clkgen i_cntr_bs_clkgen (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  cntr_bs_top i_cntr_bs_top (
    .clk_i      (clk),
    .arst_n_i   (arst_n),
    .req_i      (req),
    .ra_i       (ra),
    .t_i        (t),
    .cmd_ack_i  (cmd_ack),
    .ack_o      (ack),
    .cmd_req_o  (cmd_req),
    .cmd_ra_o   (cmd_ra),
    .cmd_type_o (cmd_type),
    .cmd_fifo_o (cmd_fifo)
  );

  // ********************
  // Compare tasks
  // ********************

  task automatic check_ra(input string name, input logic [RA-1:0] exp, input logic [RA-1:0] act);
    if (exp !== act) begin
      ra_errs++;
      $display("MISMATCH %s ra expected %02h actual %02h", name, exp, act);
    end
  endtask

  task automatic check_fifo(input string name, input logic [IDX_W-1:0] exp,
                            input logic [IDX_W-1:0] act);
    if (exp !== act) begin
      fifo_errs++;
      $display("MISMATCH %s fifo expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic check_type(input string name, input txn_type_e exp, input txn_type_e act);
    if (exp !== act) begin
      type_errs++;
      $display("MISMATCH %s type expected %s actual %s", name, exp.name(), act.name());
    end
  endtask

  task automatic flow_error(input string what);
    flow_errs++;
    $display("ERROR at %0t ns: %s", $time, what);
  endtask

  task automatic report_counts();
    $display("errors: ra %0d, fifo %0d, type %0d, handshake %0d; %0d of %0d commands checked",
             ra_errs, fifo_errs, type_errs, flow_errs, issued, NUM_TXN);
  endtask

  // ********************
  // Model rules
  // ********************

  // Hit, then empty, then below mid, then not full, inside the type's group
  function automatic int select_fifo(input logic [RA-1:0] row, input txn_type_e typ);
    int lo;
    int hi;
    int pick;
    lo   = (typ == TXN_READ) ? 0 : RD_NUM;
    hi   = (typ == TXN_READ) ? RD_NUM : FIFO_NUM;
    pick = -1;
    for (int i = lo; i < hi; i++)
      if (pick < 0 && q_ra[i].size() < `CNTR_BS_DEPTH && last_ra[i] == row) pick = i;
    for (int i = lo; i < hi; i++)
      if (pick < 0 && q_ra[i].size() == 0) pick = i;
    for (int i = lo; i < hi; i++)
      if (pick < 0 && q_ra[i].size() < `CNTR_BS_MID) pick = i;
    for (int i = lo; i < hi; i++)
      if (pick < 0 && q_ra[i].size() < `CNTR_BS_DEPTH) pick = i;
    return pick;                          // -1 means the request waits
  endfunction

  // Round robin from the pointer, wrapping 6 to 0
  function automatic int next_grant();
    int idx;
    int pick;
    pick = -1;
    for (int k = 0; k < FIFO_NUM; k++) begin
      idx = (rr_ptr + k) % FIFO_NUM;
      if (pick < 0 && q_ra[idx].size() != 0) pick = idx;
    end
    return pick;
  endfunction

  // Small row pool so hits are common, with the odd stray row
  function automatic logic [RA-1:0] pick_row(input logic [31:0] rnd);
    case (rnd[4:2])
      3'd0, 3'd1: pick_row = 8'h00;       // Matches the reset last row
      3'd2, 3'd3: pick_row = 8'h17;
      3'd4:       pick_row = 8'ha5;
      3'd5, 3'd6: pick_row = 8'hc2;
      default:    pick_row = rnd[15:8];
    endcase
  endfunction

  // ********************
  // Stimulus
  // ********************

  // Transaction source, four-phase upstream
  initial begin
    logic [31:0] rnd;
    req      = 1'b0;
    ra       = '0;
    t        = TXN_READ;
    snk_seed = $random(seed);
    wait (arst_n);
    for (int n = 0; n < NUM_TXN; n++) begin
      rnd = $random(seed);
      repeat (rnd[6:5]) @(posedge clk);  // Idle gap
      @(posedge clk);
      #1;
      ra  = pick_row(rnd);
      t   = rnd[0] ? TXN_WRITE : TXN_READ;
      req = 1'b1;
      while (!ack) begin                  // Back-pressure may hold us here
        @(posedge clk);
        #1;
      end
      req = 1'b0;
      while (ack) begin
        @(posedge clk);
        #1;
      end
    end
    src_done = 1'b1;
  end

  // Command sink with random ack delay and rare long stalls
  initial begin
    logic [31:0] rnd;
    int          delay;
    cmd_ack = 1'b0;
    wait (arst_n);
    forever begin
      @(posedge clk);
      #1;
      if (cmd_req) begin
        rnd   = $random(snk_seed);
        delay = (rnd[4:0] == 5'd0) ? 200 : int'(rnd[15:8]) % 7;
        repeat (delay) begin
          @(posedge clk);
          #1;
        end
        cmd_ack = 1'b1;
        while (cmd_req) begin
          @(posedge clk);
          #1;
        end
        cmd_ack = 1'b0;
      end
    end
  end

  // ********************
  // Model and port checks
  // ********************

  // Mid cycle sampling, prev_* hold the state seen before the last edge
  always @(negedge clk) begin
    int    push_sel;
    int    pop_sel;
    string name;
    push_sel = -1;
    pop_sel  = -1;
    if (!arst_n) begin
      if (ack || cmd_req) flow_error("ack_o or cmd_req_o high during reset");
      rr_ptr = 0;
      for (int i = 0; i < FIFO_NUM; i++) last_ra[i] = '0;
    end else begin
      if (ack && !prev_ack) begin
        if (!prev_req) flow_error("ack_o rose without req_i");
        push_sel = select_fifo(prev_ra, prev_t);
        if (push_sel < 0) flow_error("ack_o rose while every fifo of the type was full");
      end else if (prev_req && !prev_ack && select_fifo(prev_ra, prev_t) >= 0) begin
        flow_error("request left waiting although a fifo of its type had room");
      end
      if (!ack && prev_ack && prev_req) flow_error("ack_o fell while req_i was high");
      if (cmd_req && !prev_cmd_req) begin
        pop_sel = next_grant();
        if (pop_sel < 0) flow_error("command issued while every fifo was empty");
      end
      if (!cmd_req && prev_cmd_req && !prev_cmd_ack) flow_error("cmd_req_o fell before cmd_ack_i");
      // Pop and push both judged on the pre-edge state
      if (pop_sel >= 0) begin
        name = $sformatf("cmd %0d", issued);
        check_fifo(name, IDX_W'(pop_sel), cmd_fifo);
        check_ra(name, q_ra[pop_sel][0], cmd_ra);
        check_type(name, q_t[pop_sel][0], cmd_type);
        q_ra[pop_sel].delete(0);
        q_t[pop_sel].delete(0);
        rr_ptr = (pop_sel + 1) % FIFO_NUM;
        issued++;
      end
      if (push_sel >= 0) begin
        q_ra[push_sel].push_back(prev_ra);
        q_t[push_sel].push_back(prev_t);
        last_ra[push_sel] = prev_ra;     // Kept after the fifo drains
      end
    end
    prev_req     = req;
    prev_ack     = ack;
    prev_cmd_req = cmd_req;
    prev_cmd_ack = cmd_ack;
    prev_ra      = ra;
    prev_t       = t;
  end

  // ********************
  // Timeout and verdict
  // ********************

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYC) begin
      $display("ERROR: run stalled, no progress to the last command within %0d cycles", cycles);
      report_counts();
      $display(">>> FAIL");
      $finish;
    end
  end

  initial begin
    wait (src_done && issued == NUM_TXN);
    wait (!cmd_req && !cmd_ack);          // Last command handshake closed
    repeat (3) @(posedge clk);            // A stray command would have risen by now
    for (int i = 0; i < FIFO_NUM; i++) begin
      if (q_ra[i].size() != 0) flow_error($sformatf("fifo %0d not drained at the end", i));
    end
    if (cmd_req) flow_error("cmd_req_o raised again after the last command");
    report_counts();
    if (ra_errs + fifo_errs + type_errs + flow_errs == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+rtl
rtl/cntr_bs_pkg.sv
rtl/cntr_bs_sel.sv
rtl/cntr_bs_fifo.sv
rtl/cntr_bs_arb.sv
rtl/cntr_bs_ctrl.sv
rtl/cntr_bs_top.sv
bench/cntr_bs_clkgen.sv
bench/cntr_bs_assertions.sv
bench/cntr_bs_tb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, then look for the fail message in sim.log
rm -f sim.log
verilator --binary --timing --assert --top-module cntr_bs_tb -f tb.f -o cntr_bs_sim \
  && { ./obj_dir/cntr_bs_sim > sim.log 2>&1 || echo ">>> FAIL" >> sim.log; } \
  && cat sim.log \
  && ! grep -q ">>> FAIL" sim.log \
  || exit 1
